// File: glay_types_pkg.sv
/*
 * Data width constants and typedefs of the setup datapath.
 * Covers byte addresses, vertex words, cache lines, vertex
 * counts and line counts.
 */

package glay_types_pkg;

    // --------------------------------------------------
    // Width constants
    // --------------------------------------------------
    localparam int ADDR_BITS      = 32;
    localparam int VERTEX_BITS    = 32;
    localparam int VCOUNT_BITS    = 16;
    localparam int LCOUNT_BITS    = 14;

    // Four vertex words in one line
    localparam int VERTS_PER_LINE = 4;
    localparam int LINE_BITS      = VERTEX_BITS * VERTS_PER_LINE;

    // Address stride between lines
    localparam int LINE_BYTES     = LINE_BITS / 8;

    // --------------------------------------------------
    // Typedefs
    // --------------------------------------------------
    // Byte address into memory
    typedef logic [ADDR_BITS-1:0]   addr_t;

    // One vertex word
    typedef logic [VERTEX_BITS-1:0] vertex_t;

    // One cache line, word j in bits 32j+31:32j
    typedef logic [LINE_BITS-1:0]   line_t;

    // Vertex count and vertex index
    typedef logic [VCOUNT_BITS-1:0] vcount_t;

    // Line count of a run
    typedef logic [LCOUNT_BITS-1:0] lcount_t;

endpackage : glay_types_pkg

// File: glay_ctrl_pkg.sv
/*
 * Control definitions of the setup kernel.
 * Setup state machine encoding and FIFO reset-busy timing.
 */

package glay_ctrl_pkg;

    // --------------------------------------------------
    // Setup state machine
    // --------------------------------------------------
    typedef enum logic [2:0] {
        SETUP_KERNEL_RESET,
        SETUP_KERNEL_IDLE,
        SETUP_KERNEL_REQ_START,
        SETUP_KERNEL_REQ_BUSY,
        SETUP_KERNEL_REQ_DONE
    } kernel_setup_state;

    // --------------------------------------------------
    // FIFO reset-busy period
    // --------------------------------------------------
    // Cycles of rst_busy after reset release
    localparam int FIFO_RST_BUSY_CYCLES = 4;

    // Counter width for the busy period
    localparam int RST_CNT_BITS = $clog2(FIFO_RST_BUSY_CYCLES + 1);

endpackage : glay_ctrl_pkg

// File: glay_sync_fifo.sv
/*
 * Synchronous FIFO with registered read data.
 * Flags full, empty, read valid and a reset-busy period
 * during which reads and writes are ignored.
 */

`timescale 1ns/1ps

module glay_sync_fifo import glay_ctrl_pkg::*; #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             ap_clk,
    input  logic             setup_areset,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    input  logic             rd_en,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty,
    output logic             valid,
    output logic             rst_busy
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // Storage, no reset
    logic [WIDTH-1:0] mem [DEPTH];

    logic [PTR_BITS-1:0]     wr_ptr;
    logic [PTR_BITS-1:0]     rd_ptr;
    logic [CNT_BITS-1:0]     count;
    logic [RST_CNT_BITS-1:0] rst_cnt;

    logic do_wr;
    logic do_rd;

    // --------------------------------------------------
    // Flags
    // --------------------------------------------------
    assign rst_busy = (rst_cnt != '0);
    assign full     = (count == CNT_BITS'(DEPTH));
    assign empty    = (count == '0);

    // Accepted operations only
    assign do_wr = wr_en && !full && !rst_busy;
    assign do_rd = rd_en && !empty && !rst_busy;

    // --------------------------------------------------
    // Pointers, occupancy and busy counter
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            valid   <= 1'b0;
            rst_cnt <= RST_CNT_BITS'(FIFO_RST_BUSY_CYCLES);
        end else begin
            // Busy period counts down once after reset
            if (rst_busy) begin
                rst_cnt <= rst_cnt - 1'b1;
            end
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Net occupancy change
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            // Read data lands one cycle after rd_en
            valid <= do_rd;
        end
    end

    // --------------------------------------------------
    // Storage and read register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];
        end
    end

endmodule : glay_sync_fifo

// File: glay_setup_req_gen.sv
/*
 * Cache-line read address generator for one setup run.
 * Walks base, base+16, ... and limits outstanding requests.
 */

`timescale 1ns/1ps

module glay_setup_req_gen import glay_types_pkg::*; #(
    parameter int MAX_OUTSTANDING = 8
) (
    input  logic    ap_clk,
    input  logic    setup_areset,
    input  logic    start,
    input  addr_t   base,
    input  lcount_t num_lines,
    input  logic    fifo_full,
    input  logic    req_issued,
    input  logic    resp_taken,
    output logic    req_wr_en,
    output addr_t   req_addr
);

    localparam int OUT_BITS = $clog2(MAX_OUTSTANDING + 1);

    // Lines still to be written this run
    lcount_t lines_left;

    // Requests in flight, from issue until the line is taken
    logic [OUT_BITS-1:0] outstanding;
    logic                below_limit;

    // --------------------------------------------------
    // Write decision
    // --------------------------------------------------
    assign below_limit = (outstanding < OUT_BITS'(MAX_OUTSTANDING));
    assign req_wr_en   = (lines_left != '0) && !fifo_full && below_limit;

    // --------------------------------------------------
    // Line counter and outstanding count
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            lines_left  <= '0;
            outstanding <= '0;
        end else begin
            if (start) begin
                lines_left <= num_lines;
            end else if (req_wr_en) begin
                lines_left <= lines_left - 1'b1;
            end
            // Both may happen in one cycle
            if (req_issued && !resp_taken) begin
                outstanding <= outstanding + 1'b1;
            end else if (resp_taken && !req_issued) begin
                outstanding <= outstanding - 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Address register
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (start) begin
            req_addr <= base;
        end else if (req_wr_en) begin
            // Next line, one stride on
            req_addr <= req_addr + addr_t'(LINE_BYTES);
        end
    end

endmodule : glay_setup_req_gen

// File: glay_kernel_setup.sv
/*
 * Setup kernel: descriptor register, setup state machine,
 * request and response FIFOs, memory port registers and
 * the FIFO reset-busy status.
 */

`timescale 1ns/1ps

module glay_kernel_setup import glay_types_pkg::*, glay_ctrl_pkg::*; #(
    parameter int REQ_FIFO_DEPTH  = 16,
    parameter int RESP_FIFO_DEPTH = 8
) (
    input  logic    ap_clk,
    input  logic    setup_areset,
    input  logic    desc_valid,
    input  addr_t   desc_base,
    input  vcount_t desc_num_vertices,
    input  logic    mem_req_stall,
    input  logic    mem_resp_valid,
    input  line_t   mem_resp_data,
    input  logic    unpack_done,
    input  logic    line_ready,
    output logic    mem_req_valid,
    output addr_t   mem_req_addr,
    output logic    resp_line_valid,
    output line_t   resp_line_data,
    output lcount_t run_num_lines,
    output vcount_t run_num_vertices,
    output logic    setup_done,
    output logic    fifo_setup_signal
);

    kernel_setup_state current_state;
    kernel_setup_state next_state;

    // Descriptor register
    logic    desc_valid_q;
    addr_t   desc_base_q;
    vcount_t desc_num_vertices_q;
    lcount_t desc_num_lines;

    // Response input register
    logic  mem_resp_valid_q;
    line_t mem_resp_data_q;

    // Generator to request FIFO
    logic  gen_start;
    logic  req_wr_en;
    addr_t req_addr;
    logic  req_full;
    logic  req_empty;
    logic  req_rst_busy;

    // Response FIFO
    logic resp_full;
    logic resp_rst_busy;

    // --------------------------------------------------
    // Descriptor capture, only in IDLE
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            desc_valid_q <= 1'b0;
        end else begin
            desc_valid_q <= desc_valid && (current_state == SETUP_KERNEL_IDLE) && !desc_valid_q;
        end
    end

    always_ff @(posedge ap_clk) begin
        // Hold payload once a descriptor is taken
        if (desc_valid && (current_state == SETUP_KERNEL_IDLE) && !desc_valid_q) begin
            desc_base_q         <= desc_base;
            desc_num_vertices_q <= desc_num_vertices;
        end
    end

    // Lines = vertices / 4, rounded up
    assign desc_num_lines = lcount_t'((32'(desc_num_vertices_q) + VERTS_PER_LINE - 1)
                                      / VERTS_PER_LINE);

    // --------------------------------------------------
    // Setup state machine
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            current_state <= SETUP_KERNEL_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            // Wait for the FIFOs to leave reset-busy
            SETUP_KERNEL_RESET: begin
                if (!fifo_setup_signal) begin
                    next_state = SETUP_KERNEL_IDLE;
                end
            end
            SETUP_KERNEL_IDLE: begin
                if (desc_valid_q) begin
                    next_state = SETUP_KERNEL_REQ_START;
                end
            end
            SETUP_KERNEL_REQ_START: begin
                next_state = SETUP_KERNEL_REQ_BUSY;
            end
            // Run ends with the last unpacked vertex
            SETUP_KERNEL_REQ_BUSY: begin
                if (unpack_done) begin
                    next_state = SETUP_KERNEL_REQ_DONE;
                end
            end
            SETUP_KERNEL_REQ_DONE: begin
                next_state = SETUP_KERNEL_IDLE;
            end
            default: begin
                next_state = SETUP_KERNEL_RESET;
            end
        endcase
    end

    assign gen_start  = (current_state == SETUP_KERNEL_REQ_START);
    assign setup_done = (current_state == SETUP_KERNEL_REQ_DONE);

    // Run values for the unpacker
    always_ff @(posedge ap_clk) begin
        if (gen_start) begin
            run_num_lines    <= desc_num_lines;
            run_num_vertices <= desc_num_vertices_q;
        end
    end

    // --------------------------------------------------
    // Memory input register and reset-busy status
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            mem_resp_valid_q  <= 1'b0;
            fifo_setup_signal <= 1'b1;
        end else begin
            mem_resp_valid_q  <= mem_resp_valid;
            fifo_setup_signal <= req_rst_busy | resp_rst_busy;
        end
    end

    always_ff @(posedge ap_clk) begin
        mem_resp_data_q <= mem_resp_data;
    end

    // --------------------------------------------------
    // Request generator
    // --------------------------------------------------
    // Counted as outstanding from the request FIFO write on
    glay_setup_req_gen #(
        .MAX_OUTSTANDING(RESP_FIFO_DEPTH)
    ) inst_req_gen (
        .ap_clk      (ap_clk),
        .setup_areset(setup_areset),
        .start       (gen_start),
        .base        (desc_base_q),
        .num_lines   (desc_num_lines),
        .fifo_full   (req_full),
        .req_issued  (req_wr_en),
        .resp_taken  (resp_line_valid),
        .req_wr_en   (req_wr_en),
        .req_addr    (req_addr)
    );

    // --------------------------------------------------
    // Request FIFO, drains when memory does not stall
    // --------------------------------------------------
    glay_sync_fifo #(
        .WIDTH($bits(addr_t)),
        .DEPTH(REQ_FIFO_DEPTH)
    ) inst_req_fifo (
        .ap_clk      (ap_clk),
        .setup_areset(setup_areset),
        .din         (req_addr),
        .wr_en       (req_wr_en),
        .rd_en       (!req_empty && !mem_req_stall),
        .dout        (mem_req_addr),
        .full        (req_full),
        .empty       (req_empty),
        .valid       (mem_req_valid),
        .rst_busy    (req_rst_busy)
    );

    // --------------------------------------------------
    // Response FIFO, read on unpacker request
    // --------------------------------------------------
    // Never overflows, occupancy bounded by the generator limit
    glay_sync_fifo #(
        .WIDTH($bits(line_t)),
        .DEPTH(RESP_FIFO_DEPTH)
    ) inst_resp_fifo (
        .ap_clk      (ap_clk),
        .setup_areset(setup_areset),
        .din         (mem_resp_data_q),
        .wr_en       (mem_resp_valid_q && !resp_full),
        .rd_en       (line_ready),
        .dout        (resp_line_data),
        .full        (resp_full),
        .empty       (),
        .valid       (resp_line_valid),
        .rst_busy    (resp_rst_busy)
    );

endmodule : glay_kernel_setup

// File: glay_vertex_unpack.sv
/*
 * Vertex unpacker: splits response lines into indexed
 * vertex words and flags the end of a run.
 */

`timescale 1ns/1ps

module glay_vertex_unpack import glay_types_pkg::*; (
    input  logic    ap_clk,
    input  logic    setup_areset,
    input  logic    resp_line_valid,
    input  line_t   resp_line_data,
    input  vcount_t run_num_vertices,
    input  lcount_t run_num_lines,
    output logic    line_ready,
    output logic    vertex_valid,
    output vertex_t vertex_data,
    output vcount_t vertex_index,
    output logic    unpack_done
);

    localparam int WSEL_BITS = $clog2(VERTS_PER_LINE);

    // Current line, shifted one word per output
    line_t                line_q;
    logic                 busy_q;
    logic [WSEL_BITS-1:0] word_sel;
    vcount_t              vert_idx;
    logic                 last_q;

    logic last_word;
    logic last_vertex;

    assign last_word   = (word_sel == WSEL_BITS'(VERTS_PER_LINE - 1));
    assign last_vertex = (vert_idx == run_num_vertices - vcount_t'(1));

    // Ask for a line when idle and none is arriving
    assign line_ready  = !busy_q && !resp_line_valid;

    // Empty run ends at once
    assign unpack_done = last_q || (run_num_lines == '0);

    // --------------------------------------------------
    // Word sequencing
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (setup_areset) begin
            busy_q       <= 1'b0;
            word_sel     <= '0;
            vert_idx     <= '0;
            last_q       <= 1'b0;
            vertex_valid <= 1'b0;
        end else begin
            last_q       <= 1'b0;
            vertex_valid <= busy_q;
            if (resp_line_valid) begin
                busy_q   <= 1'b1;
                word_sel <= '0;
            end else if (busy_q) begin
                word_sel <= word_sel + 1'b1;
                if (last_vertex) begin
                    // Remaining words of the last line are dropped
                    busy_q   <= 1'b0;
                    vert_idx <= '0;
                    last_q   <= 1'b1;
                end else begin
                    vert_idx <= vert_idx + 1'b1;
                    if (last_word) begin
                        busy_q <= 1'b0;
                    end
                end
            end
        end
    end

    // --------------------------------------------------
    // Line register and vertex output
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (resp_line_valid) begin
            line_q <= resp_line_data;
        end else if (busy_q) begin
            line_q <= line_q >> VERTEX_BITS;
        end
        // Word 0 sits in the low bits
        vertex_data  <= vertex_t'(line_q);
        vertex_index <= vert_idx;
    end

endmodule : glay_vertex_unpack

// File: glay_setup_top.sv
/*
 * Setup stage top level.
 * Connects the setup kernel to the vertex unpacker.
 */

`timescale 1ns/1ps

module glay_setup_top import glay_types_pkg::*; #(
    parameter int REQ_FIFO_DEPTH  = 16,
    parameter int RESP_FIFO_DEPTH = 8
) (
    input  logic    ap_clk,
    input  logic    setup_areset,
    input  logic    desc_valid,
    input  addr_t   desc_base,
    input  vcount_t desc_num_vertices,
    input  logic    mem_req_stall,
    input  logic    mem_resp_valid,
    input  line_t   mem_resp_data,
    output logic    mem_req_valid,
    output addr_t   mem_req_addr,
    output logic    vertex_valid,
    output vertex_t vertex_data,
    output vcount_t vertex_index,
    output logic    setup_done,
    output logic    fifo_setup_signal
);

    // Kernel to unpacker
    logic    resp_line_valid;
    line_t   resp_line_data;
    lcount_t run_num_lines;
    vcount_t run_num_vertices;

    // Unpacker to kernel
    logic unpack_done;
    logic line_ready;

    glay_kernel_setup #(
        .REQ_FIFO_DEPTH (REQ_FIFO_DEPTH),
        .RESP_FIFO_DEPTH(RESP_FIFO_DEPTH)
    ) inst_kernel_setup (
        .ap_clk           (ap_clk),
        .setup_areset     (setup_areset),
        .desc_valid       (desc_valid),
        .desc_base        (desc_base),
        .desc_num_vertices(desc_num_vertices),
        .mem_req_stall    (mem_req_stall),
        .mem_resp_valid   (mem_resp_valid),
        .mem_resp_data    (mem_resp_data),
        .unpack_done      (unpack_done),
        .line_ready       (line_ready),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .resp_line_valid  (resp_line_valid),
        .resp_line_data   (resp_line_data),
        .run_num_lines    (run_num_lines),
        .run_num_vertices (run_num_vertices),
        .setup_done       (setup_done),
        .fifo_setup_signal(fifo_setup_signal)
    );

    glay_vertex_unpack inst_vertex_unpack (
        .ap_clk          (ap_clk),
        .setup_areset    (setup_areset),
        .resp_line_valid (resp_line_valid),
        .resp_line_data  (resp_line_data),
        .run_num_vertices(run_num_vertices),
        .run_num_lines   (run_num_lines),
        .line_ready      (line_ready),
        .vertex_valid    (vertex_valid),
        .vertex_data     (vertex_data),
        .vertex_index    (vertex_index),
        .unpack_done     (unpack_done)
    );

endmodule : glay_setup_top

// File: glay_setup_tb.sv
/*
 * Testbench of the setup stage top level.
 * Memory model with random stall and response gaps, a reference
 * model of request addresses and vertex words, and the checks.
 */

`timescale 1ns/1ps

module glay_setup_tb import glay_types_pkg::*, glay_ctrl_pkg::*; ();

    localparam int REQ_DEPTH  = 16;
    localparam int RESP_DEPTH = 8;
    localparam int NUM_RUNS   = 40;
    localparam int MAX_VERTS  = 64;
    // 200 cycles per line of the longest run, plus reset and drain
    localparam int MAX_CYCLES = NUM_RUNS * (MAX_VERTS / VERTS_PER_LINE) * 200 + 2000;
    localparam logic [31:0] DATA_MASK = 32'h5a5a0000;

    logic    ap_clk = 1'b0;
    logic    setup_areset;
    logic    desc_valid;
    addr_t   desc_base;
    vcount_t desc_num_vertices;
    logic    mem_req_stall;
    logic    mem_resp_valid;
    line_t   mem_resp_data;
    logic    mem_req_valid;
    addr_t   mem_req_addr;
    logic    vertex_valid;
    vertex_t vertex_data;
    vcount_t vertex_index;
    logic    setup_done;
    logic    fifo_setup_signal;

    // Reference model, filled when a descriptor is sent
    addr_t   exp_addr_q[$];
    vertex_t exp_data_q[$];
    vcount_t exp_index_q[$];

    // Memory model: requests waiting for an answer
    addr_t pending_q[$];
    int    stall_pct   = 0;
    int    gap_lo      = 0;
    int    gap_hi      = 0;
    int    gap_left    = 0;

    // Bookkeeping
    int   req_seen      = 0;
    int   resp_given    = 0;
    int   runs_accepted = 0;
    int   done_count    = 0;
    int   cycle_count   = 0;
    int   error_count   = 0;
    int   busy_cycles   = 0;
    logic fifo_ready    = 1'b0;
    logic stall_prev    = 1'b0;

    glay_setup_top #(
        .REQ_FIFO_DEPTH (REQ_DEPTH),
        .RESP_FIFO_DEPTH(RESP_DEPTH)
    ) UUT (
        .ap_clk           (ap_clk),
        .setup_areset     (setup_areset),
        .desc_valid       (desc_valid),
        .desc_base        (desc_base),
        .desc_num_vertices(desc_num_vertices),
        .mem_req_stall    (mem_req_stall),
        .mem_resp_valid   (mem_resp_valid),
        .mem_resp_data    (mem_resp_data),
        .mem_req_valid    (mem_req_valid),
        .mem_req_addr     (mem_req_addr),
        .vertex_valid     (vertex_valid),
        .vertex_data      (vertex_data),
        .vertex_index     (vertex_index),
        .setup_done       (setup_done),
        .fifo_setup_signal(fifo_setup_signal)
    );

    always #50 ap_clk = ~ap_clk;

    // --------------------------------------------------
    // Failure reporting and checks
    // --------------------------------------------------
    task automatic fail_and_stop();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic stop_with_error(input string what);
        error_count = error_count + 1;
        $display("ERROR time=%0t %s", $time, what);
        fail_and_stop();
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("FAIL time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            fail_and_stop();
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($urandom % n);
    endfunction

    // --------------------------------------------------
    // Output monitor, samples at the falling edge
    // --------------------------------------------------
    task automatic take_request();
        addr_t expected;
        req_seen = req_seen + 1;
        // Read happens only on a cycle without stall
        check_value("mem_req_stall before request", 0, 32'(stall_prev));
        if (exp_addr_q.size() == 0) begin
            stop_with_error("mem_req_valid while no request is expected");
        end
        expected = exp_addr_q.pop_front();
        check_value("mem_req_addr", expected, mem_req_addr);
        pending_q.push_back(mem_req_addr);
        if (req_seen - resp_given > RESP_DEPTH) begin
            stop_with_error("more requests outstanding than the response FIFO holds");
        end
    endtask

    task automatic take_vertex();
        if (exp_data_q.size() == 0) begin
            stop_with_error("vertex_valid while no vertex is expected");
        end
        check_value("vertex_data", exp_data_q.pop_front(), vertex_data);
        check_value("vertex_index", 32'(exp_index_q.pop_front()), 32'(vertex_index));
    endtask

    task automatic take_done();
        if (done_count >= runs_accepted) begin
            stop_with_error("setup_done without a run in progress");
        end
        // Run must be complete by now
        check_value("vertices left at setup_done", 0, exp_data_q.size());
        check_value("requests left at setup_done", 0, exp_addr_q.size());
        done_count = done_count + 1;
    endtask

    always @(negedge ap_clk) begin
        if (setup_areset) begin
            check_value("fifo_setup_signal", 1, 32'(fifo_setup_signal));
        end else begin
            if (!fifo_ready) begin
                if (fifo_setup_signal) begin
                    busy_cycles = busy_cycles + 1;
                    // Nothing moves during the busy period
                    check_value("mem_req_valid", 0, 32'(mem_req_valid));
                    check_value("vertex_valid", 0, 32'(vertex_valid));
                    check_value("setup_done", 0, 32'(setup_done));
                end else begin
                    check_value("fifo_setup_signal cycles", FIFO_RST_BUSY_CYCLES + 1,
                                busy_cycles);
                    fifo_ready = 1'b1;
                end
            end else begin
                check_value("fifo_setup_signal", 0, 32'(fifo_setup_signal));
            end
            if (mem_req_valid) begin
                take_request();
            end
            if (vertex_valid) begin
                take_vertex();
            end
            if (setup_done) begin
                take_done();
            end
            stall_prev = mem_req_stall;
        end
    end

    // --------------------------------------------------
    // Memory model
    // --------------------------------------------------
    task automatic send_line(input addr_t addr);
        line_t line;
        int    j;
        // Each word is its byte address XOR the mask
        for (j = 0; j < VERTS_PER_LINE; j++) begin
            line[32*j +: 32] = (addr + addr_t'(4 * j)) ^ DATA_MASK;
        end
        mem_resp_data  = line;
        mem_resp_valid = 1'b1;
        resp_given     = resp_given + 1;
    endtask

    always @(posedge ap_clk) begin
        #1;
        mem_resp_valid = 1'b0;
        if (setup_areset) begin
            mem_req_stall = 1'b0;
        end else begin
            mem_req_stall = (rand_below(100) < stall_pct);
            // In order, after a random gap
            if (pending_q.size() != 0) begin
                if (gap_left == 0) begin
                    send_line(pending_q.pop_front());
                    gap_left = gap_lo + rand_below(gap_hi - gap_lo + 1);
                end else begin
                    gap_left = gap_left - 1;
                end
            end
        end
    end

    // Run limit
    always @(posedge ap_clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            stop_with_error($sformatf("timeout, run not finished after %0d cycles",
                                      MAX_CYCLES));
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        int    run;
        int    count;
        int    lines;
        int    i;
        addr_t base;
        void'($urandom(32'hc0c4));
        setup_areset      = 1'b1;
        desc_valid        = 1'b0;
        desc_base         = '0;
        desc_num_vertices = '0;
        mem_req_stall     = 1'b0;
        mem_resp_valid    = 1'b0;
        mem_resp_data     = '0;
        repeat (8) @(posedge ap_clk);
        #1;
        setup_areset = 1'b0;
        // Kernel goes idle once the FIFOs are ready
        while (!fifo_ready) @(posedge ap_clk);
        repeat (2) @(posedge ap_clk);

        for (run = 0; run < NUM_RUNS; run++) begin
            if (run % 10 == 3) begin
                count = 0;
            end else if (run % 10 == 7) begin
                count = MAX_VERTS;
            end else begin
                count = rand_below(MAX_VERTS + 1);
            end
            base = $urandom & 32'hffff_fffc;
            case (run % 4)
                0:       stall_pct = 0;
                1:       stall_pct = 15;
                2:       stall_pct = 80;
                default: stall_pct = 35;
            endcase
            // Every fifth run has long response delays
            gap_lo = (run % 5 == 2) ? 20 : 0;
            gap_hi = (run % 5 == 2) ? 40 : 3;

            @(posedge ap_clk);
            #1;
            // Expected lines, then expected vertices
            lines = (count + VERTS_PER_LINE - 1) / VERTS_PER_LINE;
            for (i = 0; i < lines; i++) begin
                exp_addr_q.push_back(base + addr_t'(LINE_BYTES * i));
            end
            for (i = 0; i < count; i++) begin
                exp_data_q.push_back((base + addr_t'(4 * i)) ^ DATA_MASK);
                exp_index_q.push_back(vcount_t'(i));
            end
            desc_valid        = 1'b1;
            desc_base         = base;
            desc_num_vertices = vcount_t'(count);
            runs_accepted     = runs_accepted + 1;
            @(posedge ap_clk);
            #1;
            desc_valid = 1'b0;

            // Second descriptor lands while the run is busy
            if (rand_below(3) == 0) begin
                repeat (2) @(posedge ap_clk);
                #1;
                desc_valid        = 1'b1;
                desc_base         = $urandom & 32'hffff_fff0;
                desc_num_vertices = vcount_t'(1 + rand_below(MAX_VERTS));
                @(posedge ap_clk);
                #1;
                desc_valid = 1'b0;
            end

            while (done_count < runs_accepted) @(posedge ap_clk);
            repeat (rand_below(4)) @(posedge ap_clk);
        end

        // Drain, then look for stray activity
        repeat (50) @(posedge ap_clk);
        check_value("unanswered requests", 0, pending_q.size());
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : glay_setup_tb

// File: files.f
glay_types_pkg.sv
glay_ctrl_pkg.sv
glay_sync_fifo.sv
glay_setup_req_gen.sv
glay_kernel_setup.sv
glay_vertex_unpack.sv
glay_setup_top.sv
glay_setup_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the setup stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=glay_setup_tb
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module "$TOP" --Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

# The log decides the result
if grep -q "All tests passed!" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
